//--- project.f
+incdir+.
lrelu_pkg.sv
lrelu_config_ctrl.sv
lrelu_coef_store.sv
lrelu_affine_stage.sv
lrelu_activation_stage.sv
lrelu_engine.sv
tb_clock_gen.sv
lrelu_engine_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module lrelu_engine_tb -f project.f -o sim_lrelu \
  > build.log 2>&1 \
  && ./obj_dir/sim_lrelu > sim.log 2>&1 \
  || { echo "build or simulation run failed"; exit 1; }
grep -qx "TEST PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- lrelu_engine_tb.sv
`timescale 1ns/10ps
`include "lrelu_consts.svh"

module lrelu_engine_tb;

  localparam int G  = `LRELU_GROUPS;
  localparam int U  = `LRELU_UNITS;
  localparam int NW = `LRELU_GROUPS * `LRELU_UNITS;
  localparam int CH = `LRELU_CHANNELS;
  localparam int CFG_WORDS = 1 + 2 * `LRELU_CHANNELS;
  localparam int TOTAL_BEATS = 142;
  localparam int CONFIG_BEATS = 58;
  localparam int WATCHDOG_CYCLES = (TOTAL_BEATS + CONFIG_BEATS) * 8 + 200;
  localparam int DRAIN_CYCLES = 16 * `LRELU_LATENCY;

  logic clk;
  logic reset;
  logic clken;
  logic s_valid;
  logic s_lrelu;
  logic config_valid;
  logic config_reset;
  logic m_valid;
  lrelu_pkg::data_word_t [NW-1:0] s_data;
  lrelu_pkg::coef_t [G-1:0]       config_data;
  lrelu_pkg::out_word_t [NW-1:0]  m_data;

  // reference model state
  lrelu_pkg::coef_t      mod_a [G][CH];
  lrelu_pkg::coef_t      mod_b [G][CH];
  lrelu_pkg::coef_t      mod_d [G];
  lrelu_pkg::cfg_state_t mod_state;
  int                    mod_addr;
  int                    mod_ptr;
  int                    en_cycle;
  int                    stall_pct;
  int                    data_errors;
  int                    valid_errors;
  int                    latency_errors;
  lrelu_pkg::out_word_t [NW-1:0] exp_q[$];
  int                            acc_q[$];

  tb_clock_gen u_clk (.clk(clk));

  lrelu_engine u_dut (
    .clk          (clk),
    .reset        (reset),
    .clken        (clken),
    .s_valid      (s_valid),
    .s_lrelu      (s_lrelu),
    .s_data       (s_data),
    .config_valid (config_valid),
    .config_data  (config_data),
    .config_reset (config_reset),
    .m_valid      (m_valid),
    .m_data       (m_data)
  );

  function automatic int rand_range(int lo, int hi);
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  // affine, leaky, bias and clamp for one word
  function automatic lrelu_pkg::out_word_t expect_word(lrelu_pkg::data_word_t x,
      lrelu_pkg::coef_t a, lrelu_pkg::coef_t b, lrelu_pkg::coef_t d, logic lrelu);
    longint y;
    y = ((longint'(x) * longint'(a)) >>> `LRELU_FRAC) + longint'(b);
    if (lrelu && y < 0) begin
      y = (y * `LRELU_ALPHA) >>> `LRELU_FRAC;
    end
    y = y + longint'(d);
    if (y > `LRELU_SAT_MAX) begin
      y = `LRELU_SAT_MAX;
    end else if (y < `LRELU_SAT_MIN) begin
      y = `LRELU_SAT_MIN;
    end
    return lrelu_pkg::out_word_t'(y);
  endfunction

  task automatic check_out(int idx, lrelu_pkg::out_word_t got, lrelu_pkg::out_word_t exp);
    if (got !== exp) begin
      data_errors++;
      $display("mismatch m_data[%0d]: got 0x%02h exp 0x%02h", idx, got, exp);
    end
  endtask

  task automatic check_valid(logic got, logic exp, string what);
    if (got !== exp) begin
      valid_errors++;
      $display("%s", what);
    end
  endtask

  task automatic check_latency(int got);
    if (got != `LRELU_LATENCY) begin
      latency_errors++;
      $display("mismatch latency: got 0x%0h exp 0x%0h", got, `LRELU_LATENCY);
    end
  endtask

  task automatic consume_output();
    lrelu_pkg::out_word_t [NW-1:0] exp_v;
    if (exp_q.size() == 0) begin
      check_valid(1'b1, 1'b0, "m_valid went high with no beat in flight");
    end else begin
      exp_v = exp_q.pop_front();
      check_latency(en_cycle - acc_q.pop_front());
      for (int i = 0; i < NW; i++) begin
        check_out(i, m_data[i], exp_v[i]);
      end
    end
  endtask

  task automatic model_accept();
    lrelu_pkg::out_word_t [NW-1:0] exp_v;
    for (int g = 0; g < G; g++) begin
      for (int u = 0; u < U; u++) begin
        exp_v[g*U+u] = expect_word(s_data[g*U+u], mod_a[g][mod_ptr], mod_b[g][mod_ptr],
                                   mod_d[g], s_lrelu);
      end
    end
    exp_q.push_back(exp_v);
    acc_q.push_back(en_cycle);
    mod_ptr = (mod_ptr + 1) % CH;
  endtask

  // write order is D, then CH entries of A, then CH entries of B
  task automatic model_config();
    for (int g = 0; g < G; g++) begin
      case (mod_state)
        lrelu_pkg::CFG_D: mod_d[g] = config_data[g];
        lrelu_pkg::CFG_A: mod_a[g][mod_addr] = config_data[g];
        default:          mod_b[g][mod_addr] = config_data[g];
      endcase
    end
    if (mod_state == lrelu_pkg::CFG_D) begin
      mod_state = lrelu_pkg::CFG_A;
      mod_addr  = 0;
    end else if (mod_addr == CH - 1) begin
      mod_state = (mod_state == lrelu_pkg::CFG_A) ? lrelu_pkg::CFG_B : lrelu_pkg::CFG_D;
      mod_addr  = 0;
    end else begin
      mod_addr++;
    end
  endtask

  // inputs change only on the falling edge and are stable here
  always @(posedge clk) begin
    if (reset) begin
      mod_state = lrelu_pkg::CFG_D;
      mod_addr  = 0;
      mod_ptr   = 0;
      en_cycle  = 0;
      exp_q.delete();
      acc_q.delete();
    end else begin
      if (clken && m_valid) begin
        consume_output();
      end
      if (config_reset) begin
        mod_state = lrelu_pkg::CFG_D;
        mod_addr  = 0;
        mod_ptr   = 0;
      end else if (clken) begin
        if (config_valid) begin
          model_config();
        end
        if (s_valid) begin
          model_accept();
        end
      end
      if (clken) begin
        en_cycle++;
      end
    end
  end

  task automatic next_cycle();
    @(negedge clk);
    clken = (rand_range(0, 99) >= stall_pct);
  endtask

  task automatic idle_cycles(int n);
    repeat (n) begin
      next_cycle();
      s_valid      = 1'b0;
      config_valid = 1'b0;
      config_reset = 1'b0;
    end
  endtask

  // outputs are due within a bounded number of cycles, stalls included
  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
      idle_cycles(1);
      waited++;
    end
  endtask

  task automatic pulse_config_reset();
    next_cycle();
    s_valid      = 1'b0;
    config_valid = 1'b0;
    config_reset = 1'b1;
    idle_cycles(2);
  endtask

  // first n_words of the D, A, B sequence with A in units of 1/256
  task automatic load_coefs(int a_mag, int b_lo, int b_hi, int d_mag, int n_words);
    lrelu_pkg::coef_t [G-1:0] w;
    for (int k = 0; k < n_words; k++) begin
      for (int g = 0; g < G; g++) begin
        if (k == 0) begin
          w[g] = lrelu_pkg::coef_t'(rand_range(-d_mag, d_mag - 1));
        end else if (k <= CH) begin
          w[g] = lrelu_pkg::coef_t'(rand_range(-a_mag, a_mag - 1));
        end else begin
          w[g] = lrelu_pkg::coef_t'(rand_range(b_lo, b_hi));
        end
      end
      do begin
        next_cycle();
        s_valid      = 1'b0;
        config_valid = 1'b1;
        config_data  = w;
      end while (!clken);
    end
    idle_cycles(1);
  endtask

  // lrelu_mode 2 picks the flag per beat
  task automatic send_beats(int n, int x_mag, int lrelu_mode);
    lrelu_pkg::data_word_t [NW-1:0] x;
    logic lr;
    for (int k = 0; k < n; k++) begin
      for (int i = 0; i < NW; i++) begin
        x[i] = lrelu_pkg::data_word_t'(rand_range(-x_mag, x_mag - 1));
      end
      lr = (lrelu_mode == 2) ? logic'($urandom % 2) : logic'(lrelu_mode);
      do begin
        next_cycle();
        config_valid = 1'b0;
        s_valid      = 1'b1;
        s_lrelu      = lr;
        s_data       = x;
      end while (!clken);
    end
    idle_cycles(1);
    wait_drain();
  endtask

  initial begin
    void'($urandom(32'hd240));
    reset          = 1'b1;
    clken          = 1'b1;
    s_valid        = 1'b0;
    s_lrelu        = 1'b0;
    s_data         = '0;
    config_valid   = 1'b0;
    config_data    = '0;
    config_reset   = 1'b0;
    stall_pct      = 0;
    data_errors    = 0;
    valid_errors   = 0;
    latency_errors = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // m_valid must stay low with no input
    idle_cycles(20);
    // plain affine over ten channel rotations
    load_coefs(256, -32, 31, 16, CFG_WORDS);
    send_beats(40, 128, 0);
    // negative offsets so most words take the leaky slope
    load_coefs(256, -96, 16, 16, CFG_WORDS);
    send_beats(24, 128, 1);
    // full range coefficients push past both limits
    load_coefs(32768, -32768, 32767, 32768, CFG_WORDS);
    send_beats(24, 32768, 2);
    // random clken stalls
    stall_pct = 40;
    load_coefs(256, -32, 31, 16, CFG_WORDS);
    send_beats(40, 128, 2);
    stall_pct = 0;
    // config reset after data beats and in the middle of a load
    load_coefs(256, -32, 31, 16, CFG_WORDS);
    send_beats(6, 128, 0);
    pulse_config_reset();
    load_coefs(256, -32, 31, 16, 4);
    pulse_config_reset();
    load_coefs(384, -48, 47, 24, CFG_WORDS);
    send_beats(8, 128, 2);
    idle_cycles(10);
    check_valid(exp_q.size() != 0, 1'b0, "beats still in flight at the end of the run");
    $display("errors: data %0d, valid %0d, latency %0d", data_errors, valid_errors,
             latency_errors);
    if (data_errors + valid_errors + latency_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired before the test sequence finished");
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

endmodule

//--- lrelu_engine.sv
`timescale 1ns/10ps
`include "lrelu_consts.svh"

module lrelu_engine (
  input  logic                                                  clk,
  input  logic                                                  reset,
  input  logic                                                  clken,
  input  logic                                                  s_valid,
  input  logic                                                  s_lrelu,
  input  lrelu_pkg::data_word_t [`LRELU_GROUPS*`LRELU_UNITS-1:0] s_data,
  input  logic                                                  config_valid,
  input  lrelu_pkg::coef_t [`LRELU_GROUPS-1:0]                  config_data,
  input  logic                                                  config_reset,
  output logic                                                  m_valid,
  output lrelu_pkg::out_word_t [`LRELU_GROUPS*`LRELU_UNITS-1:0] m_data
);

  // config sequencer to store
  logic                  wr_d;
  logic                  wr_a;
  logic                  wr_b;
  lrelu_pkg::chan_addr_t wr_addr;

  // coefficients for the beat at the port
  lrelu_pkg::coef_t [`LRELU_GROUPS-1:0] a_coefs;
  lrelu_pkg::coef_t [`LRELU_GROUPS-1:0] b_coefs;
  lrelu_pkg::coef_t [`LRELU_GROUPS-1:0] d_coefs;

  // affine result, two enabled cycles after acceptance
  logic                                               aff_valid;
  logic                                               aff_lrelu;
  lrelu_pkg::acc_t [`LRELU_GROUPS*`LRELU_UNITS-1:0]   aff_data;

  lrelu_config_ctrl u_cfg (
    .clk          (clk),
    .reset        (reset),
    .clken        (clken),
    .config_valid (config_valid),
    .config_reset (config_reset),
    .wr_d         (wr_d),
    .wr_a         (wr_a),
    .wr_b         (wr_b),
    .wr_addr      (wr_addr)
  );

  lrelu_coef_store u_store (
    .clk          (clk),
    .reset        (reset),
    .clken        (clken),
    .config_reset (config_reset),
    .wr_d         (wr_d),
    .wr_a         (wr_a),
    .wr_b         (wr_b),
    .wr_addr      (wr_addr),
    .config_data  (config_data),
    .s_valid      (s_valid),
    .a_coefs      (a_coefs),
    .b_coefs      (b_coefs),
    .d_coefs      (d_coefs)
  );

  lrelu_affine_stage u_affine (
    .clk       (clk),
    .reset     (reset),
    .clken     (clken),
    .s_valid   (s_valid),
    .s_lrelu   (s_lrelu),
    .s_data    (s_data),
    .a_coefs   (a_coefs),
    .b_coefs   (b_coefs),
    .aff_valid (aff_valid),
    .aff_lrelu (aff_lrelu),
    .aff_data  (aff_data)
  );

  lrelu_activation_stage u_act (
    .clk       (clk),
    .reset     (reset),
    .clken     (clken),
    .aff_valid (aff_valid),
    .aff_lrelu (aff_lrelu),
    .aff_data  (aff_data),
    .d_coefs   (d_coefs),
    .m_valid   (m_valid),
    .m_data    (m_data)
  );

endmodule

//--- lrelu_activation_stage.sv
`timescale 1ns/10ps
`include "lrelu_consts.svh"

module lrelu_activation_stage (
  input  logic                                                  clk,
  input  logic                                                  reset,
  input  logic                                                  clken,
  input  logic                                                  aff_valid,
  input  logic                                                  aff_lrelu,
  input  lrelu_pkg::acc_t [`LRELU_GROUPS*`LRELU_UNITS-1:0]      aff_data,
  input  lrelu_pkg::coef_t [`LRELU_GROUPS-1:0]                  d_coefs,
  output logic                                                  m_valid,
  output lrelu_pkg::out_word_t [`LRELU_GROUPS*`LRELU_UNITS-1:0] m_data
);

  lrelu_pkg::acc_t      leaky  [`LRELU_GROUPS*`LRELU_UNITS];
  lrelu_pkg::acc_t      biased [`LRELU_GROUPS*`LRELU_UNITS];
  lrelu_pkg::out_word_t clamped[`LRELU_GROUPS*`LRELU_UNITS];
  logic                 leaky_valid;

  always_ff @(posedge clk) begin
    if (reset) begin
      leaky_valid <= 1'b0;
      m_valid     <= 1'b0;
    end else if (clken) begin
      leaky_valid <= aff_valid;
      m_valid     <= leaky_valid;
    end
  end

  // negative words of an lrelu beat are scaled by alpha/256
  always_ff @(posedge clk) begin
    if (clken) begin
      for (int i = 0; i < `LRELU_GROUPS*`LRELU_UNITS; i++) begin
        if (aff_lrelu && aff_data[i][`LRELU_ACC_W-1]) begin
          leaky[i] <= ($signed(aff_data[i]) * lrelu_pkg::acc_t'(`LRELU_ALPHA)) >>> `LRELU_FRAC;
        end else begin
          leaky[i] <= aff_data[i];
        end
      end
    end
  end

  // D only changes between jobs, so it is taken straight from the store
  always_comb begin
    for (int g = 0; g < `LRELU_GROUPS; g++) begin
      for (int u = 0; u < `LRELU_UNITS; u++) begin
        biased[g*`LRELU_UNITS+u] = leaky[g*`LRELU_UNITS+u]
                                 + lrelu_pkg::acc_t'($signed(d_coefs[g]));
      end
    end
  end

  // clamp to the signed 8 bit range
  always_comb begin
    for (int i = 0; i < `LRELU_GROUPS*`LRELU_UNITS; i++) begin
      if (biased[i] > `LRELU_SAT_MAX) begin
        clamped[i] = lrelu_pkg::out_word_t'(`LRELU_SAT_MAX);
      end else if (biased[i] < `LRELU_SAT_MIN) begin
        clamped[i] = lrelu_pkg::out_word_t'(`LRELU_SAT_MIN);
      end else begin
        clamped[i] = lrelu_pkg::out_word_t'(biased[i]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      for (int i = 0; i < `LRELU_GROUPS*`LRELU_UNITS; i++) begin
        m_data[i] <= clamped[i];
      end
    end
  end

endmodule

//--- lrelu_affine_stage.sv
`timescale 1ns/10ps
`include "lrelu_consts.svh"

module lrelu_affine_stage (
  input  logic                                                    clk,
  input  logic                                                    reset,
  input  logic                                                    clken,
  input  logic                                                    s_valid,
  input  logic                                                    s_lrelu,
  input  lrelu_pkg::data_word_t [`LRELU_GROUPS*`LRELU_UNITS-1:0]  s_data,
  input  lrelu_pkg::coef_t [`LRELU_GROUPS-1:0]                    a_coefs,
  input  lrelu_pkg::coef_t [`LRELU_GROUPS-1:0]                    b_coefs,
  output logic                                                    aff_valid,
  output logic                                                    aff_lrelu,
  output lrelu_pkg::acc_t [`LRELU_GROUPS*`LRELU_UNITS-1:0]        aff_data
);

  lrelu_pkg::acc_t  prod   [`LRELU_GROUPS*`LRELU_UNITS];
  lrelu_pkg::coef_t b_hold [`LRELU_GROUPS];
  logic             prod_valid;
  logic             prod_lrelu;

  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
      aff_valid  <= 1'b0;
    end else if (clken) begin
      prod_valid <= s_valid;
      aff_valid  <= prod_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      prod_lrelu <= s_lrelu;
      aff_lrelu  <= prod_lrelu;
      for (int g = 0; g < `LRELU_GROUPS; g++) begin
        // B of this channel must follow the beat, the pointer moves on
        b_hold[g] <= b_coefs[g];
        for (int u = 0; u < `LRELU_UNITS; u++) begin
          // full 32 bit product, no rounding
          prod[g*`LRELU_UNITS+u] <= lrelu_pkg::acc_t'($signed(s_data[g*`LRELU_UNITS+u]))
                                  * lrelu_pkg::acc_t'($signed(a_coefs[g]));
        end
      end
      // drop the Q8.8 fraction of A, then offset by B
      for (int g = 0; g < `LRELU_GROUPS; g++) begin
        for (int u = 0; u < `LRELU_UNITS; u++) begin
          aff_data[g*`LRELU_UNITS+u] <= (prod[g*`LRELU_UNITS+u] >>> `LRELU_FRAC)
                                      + lrelu_pkg::acc_t'(b_hold[g]);
        end
      end
    end
  end

endmodule

//--- lrelu_coef_store.sv
`timescale 1ns/10ps
`include "lrelu_consts.svh"

module lrelu_coef_store (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    clken,
  input  logic                                    config_reset,
  input  logic                                    wr_d,
  input  logic                                    wr_a,
  input  logic                                    wr_b,
  input  lrelu_pkg::chan_addr_t                   wr_addr,
  input  lrelu_pkg::coef_t [`LRELU_GROUPS-1:0]    config_data,
  input  logic                                    s_valid,
  output lrelu_pkg::coef_t [`LRELU_GROUPS-1:0]    a_coefs,
  output lrelu_pkg::coef_t [`LRELU_GROUPS-1:0]    b_coefs,
  output lrelu_pkg::coef_t [`LRELU_GROUPS-1:0]    d_coefs
);

  lrelu_pkg::coef_t      a_mem [`LRELU_GROUPS][`LRELU_CHANNELS];
  lrelu_pkg::coef_t      b_mem [`LRELU_GROUPS][`LRELU_CHANNELS];
  lrelu_pkg::coef_t      d_reg [`LRELU_GROUPS];
  lrelu_pkg::chan_addr_t rd_ptr;

  // every group takes its own word of config_data on the same strobe
  always_ff @(posedge clk) begin
    for (int g = 0; g < `LRELU_GROUPS; g++) begin
      if (wr_a) begin
        a_mem[g][wr_addr] <= config_data[g];
      end
      if (wr_b) begin
        b_mem[g][wr_addr] <= config_data[g];
      end
      if (wr_d) begin
        d_reg[g] <= config_data[g];
      end
    end
  end

  // channel rotation, one step per accepted data beat
  always_ff @(posedge clk) begin
    if (reset || config_reset) begin
      rd_ptr <= '0;
    end else if (clken && s_valid) begin
      if (rd_ptr == lrelu_pkg::chan_addr_t'(`LRELU_CHANNELS - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // asynchronous read so the beat at the port sees its own channel
  always_comb begin
    for (int g = 0; g < `LRELU_GROUPS; g++) begin
      a_coefs[g] = a_mem[g][rd_ptr];
      b_coefs[g] = b_mem[g][rd_ptr];
      d_coefs[g] = d_reg[g];
    end
  end

endmodule

//--- lrelu_config_ctrl.sv
`timescale 1ns/10ps
`include "lrelu_consts.svh"

module lrelu_config_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  clken,
  input  logic                  config_valid,
  input  logic                  config_reset,
  output logic                  wr_d,
  output logic                  wr_a,
  output logic                  wr_b,
  output lrelu_pkg::chan_addr_t wr_addr
);

  lrelu_pkg::cfg_state_t state;
  lrelu_pkg::cfg_state_t state_next;
  lrelu_pkg::chan_addr_t addr;
  lrelu_pkg::chan_addr_t addr_next;
  logic                  cfg_beat;
  logic                  addr_last;

  // a config reset in the same cycle wins over the word on the port
  assign cfg_beat  = config_valid && clken && !config_reset;
  assign addr_last = (addr == lrelu_pkg::chan_addr_t'(`LRELU_CHANNELS - 1));

  always_comb begin
    state_next = state;
    addr_next  = addr;
    unique case (state)
      lrelu_pkg::CFG_D: begin
        // single D word per group, A memory follows from entry 0
        state_next = lrelu_pkg::CFG_A;
        addr_next  = '0;
      end
      lrelu_pkg::CFG_A: begin
        if (addr_last) begin
          state_next = lrelu_pkg::CFG_B;
          addr_next  = '0;
        end else begin
          addr_next = addr + 1'b1;
        end
      end
      default: begin
        // last B entry closes the sequence, next word is D again
        if (addr_last) begin
          state_next = lrelu_pkg::CFG_D;
          addr_next  = '0;
        end else begin
          addr_next = addr + 1'b1;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset || config_reset) begin
      state <= lrelu_pkg::CFG_D;
      addr  <= '0;
    end else if (cfg_beat) begin
      state <= state_next;
      addr  <= addr_next;
    end
  end

  assign wr_d    = cfg_beat && (state == lrelu_pkg::CFG_D);
  assign wr_a    = cfg_beat && (state == lrelu_pkg::CFG_A);
  assign wr_b    = cfg_beat && (state == lrelu_pkg::CFG_B);
  assign wr_addr = addr;

endmodule

//--- lrelu_pkg.sv
`include "lrelu_consts.svh"

package lrelu_pkg;

  // raw input word from the conv engine
  typedef logic signed [`LRELU_IN_W-1:0] data_word_t;

  // A is Q8.8, B and D are plain integers
  typedef logic signed [`LRELU_COEF_W-1:0] coef_t;

  // wide enough that nothing wraps before the final clamp
  typedef logic signed [`LRELU_ACC_W-1:0] acc_t;

  typedef logic signed [`LRELU_OUT_W-1:0] out_word_t;

  // selects one of the per-channel A/B entries
  typedef logic [$clog2(`LRELU_CHANNELS)-1:0] chan_addr_t;

  // coefficient write order: D register, then A memory, then B memory
  typedef enum logic [1:0] {
    CFG_D,
    CFG_A,
    CFG_B
  } cfg_state_t;

endpackage

//--- lrelu_consts.svh
`ifndef LRELU_CONSTS_SVH
`define LRELU_CONSTS_SVH

// beat geometry
`define LRELU_UNITS     4
`define LRELU_GROUPS    2
`define LRELU_CHANNELS  4

// word widths
`define LRELU_IN_W      16
`define LRELU_COEF_W    16
`define LRELU_ACC_W     32
`define LRELU_OUT_W     8

// A and alpha carry 8 fraction bits, alpha is about 0.1
`define LRELU_FRAC      8
`define LRELU_ALPHA     26

// signed 8 bit output range
`define LRELU_SAT_MAX   127
`define LRELU_SAT_MIN   (-128)

// enabled cycles from accepted beat to m_valid
`define LRELU_LATENCY   4

`endif
